/* rtl/ipod_pkg.sv */
package ipod_pkg;

  // ====================
  // Rates and periods
  // ====================

  // System clock
  localparam int CLK_HZ = 50_000_000;

  // Default sample period in clocks, about 22 kHz
  localparam int BASE_PERIOD = 2272;
  // One key step
  localparam int SPEED_STEP = 100;
  // Clamp range of the period
  localparam int MIN_PERIOD = 272;
  localparam int MAX_PERIOD = 9972;
  // Auto-repeat spacing while a key is held, 10 steps per second
  localparam int REPEAT_CYCLES = CLK_HZ / 10;

  // ====================
  // Flash and outputs
  // ====================

  // Word address width of the flash
  localparam int FLASH_AW = 19;

  // Loudness block length, power of two
  localparam int AVG_SAMPLES = 16;
  localparam int LED_COUNT = 8;
  localparam int SEG_DIGITS = 6;

  // Basic types
  typedef logic signed [15:0] sample_t;
  typedef logic [15:0] period_t;
  typedef logic [FLASH_AW-1:0] flash_addr_t;
  // Active-low segments, bit 0 is segment a
  typedef logic [6:0] seg_t;

  // Top word of the flash
  localparam flash_addr_t LAST_WORD = '1;

  // Keyboard command letters in ASCII
  typedef enum logic [7:0] {
    CMD_PLAY    = 8'h45,
    CMD_PAUSE   = 8'h44,
    CMD_FWD     = 8'h46,
    CMD_BWD     = 8'h42,
    CMD_RESTART = 8'h52
  } cmd_e;

  // Player fetch FSM
  typedef enum logic [1:0] {
    IDLE,
    FETCH,
    WAIT_DATA,
    HAVE_WORD
  } play_state_e;

  // Flash read request, from the player
  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  // Flash response
  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    logic [31:0] readdata;
  } flash_rsp_t;

  // Raw speed keys, all active low
  typedef struct packed {
    logic up_n;
    logic down_n;
    logic reset_n;
  } speed_keys_t;

endpackage

/* rtl/sample_rate_ctrl.sv */
`timescale 1ns/1ps

module sample_rate_ctrl (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  ipod_pkg::speed_keys_t keys,
  output ipod_pkg::period_t     period,
  output logic                  sample_tick
);
  import ipod_pkg::*;

  // Two sync stages plus one history stage for edge detect
  speed_keys_t keys_s1;
  speed_keys_t keys_s2;
  speed_keys_t keys_s3;

  logic up_press;
  logic down_press;
  logic rst_press;
  logic up_step;
  logic down_step;
  logic any_held;
  logic rep_done;
  logic [$clog2(REPEAT_CYCLES)-1:0] rep_cnt;
  period_t period_next;
  period_t tick_cnt;

  // ====================
  // Key sync and edges
  // ====================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      // Keys idle high
      keys_s1 <= '1;
      keys_s2 <= '1;
      keys_s3 <= '1;
    end
    else
    begin
      keys_s1 <= keys;
      keys_s2 <= keys_s1;
      keys_s3 <= keys_s2;
    end
  end

  // Falling edge of the synchronized level
  assign up_press   = keys_s3.up_n & ~keys_s2.up_n;
  assign down_press = keys_s3.down_n & ~keys_s2.down_n;
  assign rst_press  = keys_s3.reset_n & ~keys_s2.reset_n;

  assign any_held = ~keys_s2.up_n | ~keys_s2.down_n;
  assign rep_done = (rep_cnt == REPEAT_CYCLES - 1);

  // First step on the press, then one per repeat interval
  assign up_step   = up_press | (~keys_s2.up_n & rep_done);
  assign down_step = down_press | (~keys_s2.down_n & rep_done);

  // Repeat timer restarts on every new press
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      rep_cnt <= '0;
    else if (!any_held || up_press || down_press || rep_done)
      rep_cnt <= '0;
    else
      rep_cnt <= rep_cnt + 1'b1;
  end

  // ====================
  // Period register
  // ====================
  always_comb
  begin
    period_next = period;
    if (rst_press)
      period_next = period_t'(BASE_PERIOD);
    else if (up_step)
    begin
      // Shorter period, faster playback
      if (period < MIN_PERIOD + SPEED_STEP)
        period_next = period_t'(MIN_PERIOD);
      else
        period_next = period - period_t'(SPEED_STEP);
    end
    else if (down_step)
    begin
      if (period > MAX_PERIOD - SPEED_STEP)
        period_next = period_t'(MAX_PERIOD);
      else
        period_next = period + period_t'(SPEED_STEP);
    end
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      period <= period_t'(BASE_PERIOD);
    else
      period <= period_next;
  end

  // Tick every period clocks
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_cnt    <= period_t'(BASE_PERIOD - 1);
      sample_tick <= 1'b0;
    end
    else if (tick_cnt == '0)
    begin
      tick_cnt    <= period - 1'b1;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_cnt    <= tick_cnt - 1'b1;
      sample_tick <= 1'b0;
    end
  end

  // Period never leaves its clamp range once out of reset
  a_period_range: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    ##1 (period >= MIN_PERIOD && period <= MAX_PERIOD))
    else $error("sample period %0d outside limits", period);

endmodule

/* rtl/player_ctrl.sv */
`timescale 1ns/1ps

module player_ctrl (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  logic [7:0]           kbd_ascii,
  input  logic                 kbd_valid,
  input  logic                 sample_tick,
  output ipod_pkg::flash_req_t flash_req,
  input  ipod_pkg::flash_rsp_t flash_rsp,
  output ipod_pkg::sample_t    sample,
  output logic                 sample_valid
);
  import ipod_pkg::*;

  play_state_e state;
  cmd_e        cmd;

  // Play flag and direction, forward when low
  logic playing;
  logic dir_bwd;
  // Play position and latched request address
  flash_addr_t addr;
  flash_addr_t rd_addr;
  flash_addr_t next_addr;
  logic [31:0] word_buf;
  // Pending read was made stale by a command
  logic drop;
  logic discard;
  logic tick_go;

  assign cmd = cmd_e'(kbd_ascii);

  // Restart or a direction change throws the buffer away
  assign discard = kbd_valid &&
                   ((cmd == CMD_RESTART) ||
                    (cmd == CMD_FWD && dir_bwd) ||
                    (cmd == CMD_BWD && !dir_bwd));

  assign tick_go = sample_tick && playing && !discard;

  // Step through the flash with wrap at both ends
  assign next_addr = dir_bwd ? ((addr == '0) ? LAST_WORD : addr - 1'b1)
                             : ((addr == LAST_WORD) ? '0 : addr + 1'b1);

  assign flash_req = '{read: (state == FETCH), address: rd_addr};

  // ====================
  // Commands and fetch FSM
  // ====================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= IDLE;
      playing      <= 1'b0;
      dir_bwd      <= 1'b0;
      addr         <= '0;
      rd_addr      <= '0;
      drop         <= 1'b0;
      sample       <= '0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;

      // Other letters fall through
      if (kbd_valid)
      begin
        case (cmd)
          CMD_PLAY:    playing <= 1'b1;
          CMD_PAUSE:   playing <= 1'b0;
          CMD_FWD:     dir_bwd <= 1'b0;
          CMD_BWD:     dir_bwd <= 1'b1;
          CMD_RESTART: addr <= dir_bwd ? LAST_WORD : '0;
          default:     ;
        endcase
      end

      case (state)
        IDLE:
        begin
          // Nothing buffered, tick starts a read of the current word
          if (tick_go)
          begin
            rd_addr <= addr;
            drop    <= 1'b0;
            state   <= FETCH;
          end
        end
        FETCH:
        begin
          // Accepted on the edge that sees waitrequest low
          if (!flash_rsp.waitrequest)
            state <= WAIT_DATA;
        end
        WAIT_DATA:
        begin
          if (flash_rsp.readdatavalid)
          begin
            if (drop || discard || !playing)
              state <= IDLE;
            else
            begin
              // First half goes out now
              word_buf     <= flash_rsp.readdata;
              sample       <= dir_bwd ? flash_rsp.readdata[31:16]
                                      : flash_rsp.readdata[15:0];
              sample_valid <= 1'b1;
              state        <= HAVE_WORD;
            end
          end
        end
        HAVE_WORD:
        begin
          // Exactly one unplayed half left in the buffer
          if (discard)
            state <= IDLE;
          else if (tick_go)
          begin
            sample       <= dir_bwd ? word_buf[15:0] : word_buf[31:16];
            sample_valid <= 1'b1;
            addr         <= next_addr;
            state        <= IDLE;
          end
        end
        default:
          state <= IDLE;
      endcase

      // Read in flight stays on the bus, its data is dropped
      if (discard && (state == FETCH || state == WAIT_DATA))
        drop <= 1'b1;
    end
  end

  // ====================
  // Checks
  // ====================
  a_addr_stable: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_req.read && flash_rsp.waitrequest |=>
      flash_req.read && $stable(flash_req.address))
    else $error("flash read dropped or address moved under waitrequest");

  a_no_orphan_data: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_rsp.readdatavalid |-> state == WAIT_DATA)
    else $error("readdatavalid with no read outstanding");

  // Bounded flash latency keeps every fetch inside one period
  a_tick_not_lost: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    sample_tick |-> !(state inside {FETCH, WAIT_DATA}))
    else $error("sample tick landed on a pending fetch");

endmodule

/* rtl/level_meter.sv */
`timescale 1ns/1ps

module level_meter (
  input  logic                                CLK_50M,
  input  logic                                arst_n,
  input  ipod_pkg::sample_t                   sample,
  input  logic                                sample_valid,
  output logic [ipod_pkg::LED_COUNT-1:0]      led_bar,
  output logic                                led_beat
);
  import ipod_pkg::*;

  logic signed [7:0] hi_byte;
  // Magnitude 0 to 128
  logic [7:0] mag;
  // Room for a full block of 128s
  logic [7+$clog2(AVG_SAMPLES):0] acc;
  logic [7+$clog2(AVG_SAMPLES):0] acc_sum;
  logic [$clog2(AVG_SAMPLES)-1:0] blk_cnt;
  logic [7:0] avg;

  assign hi_byte = sample[15:8];
  // -128 wraps to 8'h80, read as unsigned 128
  assign mag     = hi_byte[7] ? -hi_byte : hi_byte;
  assign acc_sum = acc + mag;
  assign avg     = 8'(acc_sum >> $clog2(AVG_SAMPLES));

  // ====================
  // Block average
  // ====================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      acc      <= '0;
      blk_cnt  <= '0;
      led_bar  <= '0;
      led_beat <= 1'b0;
    end
    else if (sample_valid)
    begin
      blk_cnt <= blk_cnt + 1'b1;
      if (blk_cnt == AVG_SAMPLES - 1)
      begin
        // Bar graph, one LED per 16 steps of average
        for (int k = 0; k < LED_COUNT; k++)
          led_bar[k] <= (avg >= 16 * (k + 1));
        led_beat <= ~led_beat;
        acc      <= '0;
      end
      else
        acc <= acc_sum;
    end
  end

endmodule

/* rtl/hex_display.sv */
`timescale 1ns/1ps

module hex_display (
  input  ipod_pkg::period_t                           period,
  output ipod_pkg::seg_t [ipod_pkg::SEG_DIGITS-1:0]   hex
);
  import ipod_pkg::*;

  // Period zero-extended across all digits
  logic [4*SEG_DIGITS-1:0] digit_val;

  // Active-low patterns, segment a in bit 0
  function automatic seg_t hex_seg(input logic [3:0] nib);
    case (nib)
      4'h0:    hex_seg = 7'h40;
      4'h1:    hex_seg = 7'h79;
      4'h2:    hex_seg = 7'h24;
      4'h3:    hex_seg = 7'h30;
      4'h4:    hex_seg = 7'h19;
      4'h5:    hex_seg = 7'h12;
      4'h6:    hex_seg = 7'h02;
      4'h7:    hex_seg = 7'h78;
      4'h8:    hex_seg = 7'h00;
      4'h9:    hex_seg = 7'h10;
      4'hA:    hex_seg = 7'h08;
      // Lower-case b and d
      4'hB:    hex_seg = 7'h03;
      4'hC:    hex_seg = 7'h46;
      4'hD:    hex_seg = 7'h21;
      4'hE:    hex_seg = 7'h06;
      default: hex_seg = 7'h0E;
    endcase
  endfunction

  // Upper digits read 0
  assign digit_val = (4*SEG_DIGITS)'(period);

  // ====================
  // Per-digit decode
  // ====================
  always_comb
  begin
    for (int i = 0; i < SEG_DIGITS; i++)
      hex[i] = hex_seg(digit_val[4*i +: 4]);
  end

endmodule

/* rtl/ipod_top.sv */
`timescale 1ns/1ps

module ipod_top (
  input  logic                                        CLK_50M,
  input  logic                                        arst_n,
  input  logic [7:0]                                  kbd_ascii,
  input  logic                                        kbd_valid,
  input  ipod_pkg::speed_keys_t                       keys,
  input  ipod_pkg::flash_rsp_t                        flash_rsp,
  output ipod_pkg::flash_req_t                        flash_req,
  output ipod_pkg::sample_t                           sample,
  output logic                                        sample_valid,
  output logic [ipod_pkg::LED_COUNT-1:0]              led_bar,
  output logic                                        led_beat,
  output ipod_pkg::seg_t [ipod_pkg::SEG_DIGITS-1:0]   hex
);
  import ipod_pkg::*;

  // Rate control to player and display
  period_t period;
  logic    sample_tick;

  sample_rate_ctrl u_rate (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .keys        (keys),
    .period      (period),
    .sample_tick (sample_tick)
  );

  // Flash master and sample stream
  player_ctrl u_player (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .kbd_ascii    (kbd_ascii),
    .kbd_valid    (kbd_valid),
    .sample_tick  (sample_tick),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid)
  );

  // Loudness bar follows the output samples
  level_meter u_meter (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .sample       (sample),
    .sample_valid (sample_valid),
    .led_bar      (led_bar),
    .led_beat     (led_beat)
  );

  hex_display u_hex (
    .period (period),
    .hex    (hex)
  );

endmodule

/* dv/flash_model.sv */
`timescale 1ns/1ps

module flash_model (
  input  logic                 CLK_50M,
  input  logic                 arst_n,
  input  ipod_pkg::flash_req_t req,
  output ipod_pkg::flash_rsp_t rsp
);
  import ipod_pkg::*;

  // Fixed seed, same jitter on every run
  int seed = 32'ha3a9_b2ca;
  // Wait states still owed to the next read
  int wait_left;
  int next_wait;
  // Cycles until readdatavalid
  int lat_left;
  logic busy;
  flash_addr_t addr_q;

  // ====================
  // Read responder
  // ====================
  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rsp       <= '0;
      wait_left <= 0;
      lat_left  <= 0;
      busy      <= 1'b0;
      addr_q    <= '0;
    end
    else
    begin
      rsp.readdatavalid <= 1'b0;
      if (req.read && rsp.waitrequest)
      begin
        // One stall cycle used up
        wait_left       <= wait_left - 1;
        rsp.waitrequest <= (wait_left > 1);
      end
      else if (req.read)
      begin
        // Accepted here, draw latency and the stall for the next read
        next_wait       = $unsigned($random(seed)) % 4;
        addr_q          <= req.address;
        lat_left        <= 1 + $unsigned($random(seed)) % 4;
        busy            <= 1'b1;
        wait_left       <= next_wait;
        rsp.waitrequest <= (next_wait != 0);
      end
      if (busy)
      begin
        if (lat_left == 1)
        begin
          // High half 2a+1, low half 2a, both cut to 16 bits
          rsp.readdata      <= {addr_q[14:0], 1'b1, addr_q[14:0], 1'b0};
          rsp.readdatavalid <= 1'b1;
          busy              <= 1'b0;
        end
        else
          lat_left <= lat_left - 1;
      end
    end
  end

endmodule

/* dv/tb_ipod.sv */
`timescale 1ns/1ps

module tb_ipod;
  import ipod_pkg::*;

  // ====================
  // Constants
  // ====================
  // About 300 samples at twice the base period, plus the key tests
  localparam int TIMEOUT_CYCLES = 2_000_000;
  // Key hold, far shorter than the auto-repeat interval
  localparam int KEY_HOLD = 10;
  // Drift allowed over 8 sample intervals from flash stalls
  localparam int SPACING_SLACK = 16;
  localparam speed_keys_t KEYS_IDLE = '{up_n: 1'b1, down_n: 1'b1, reset_n: 1'b1};
  localparam speed_keys_t KEY_UP    = '{up_n: 1'b0, down_n: 1'b1, reset_n: 1'b1};
  localparam speed_keys_t KEY_DOWN  = '{up_n: 1'b1, down_n: 1'b0, reset_n: 1'b1};
  localparam speed_keys_t KEY_RST   = '{up_n: 1'b1, down_n: 1'b1, reset_n: 1'b0};
  // Active-low digit shapes 0 to F, segment a in bit 0
  localparam logic [6:0] SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

  logic CLK_50M = 1'b0;
  logic arst_n;
  logic [7:0] kbd_ascii;
  logic kbd_valid;
  speed_keys_t keys;
  flash_req_t flash_req;
  flash_rsp_t flash_rsp;
  sample_t sample;
  logic sample_valid;
  logic [LED_COUNT-1:0] led_bar;
  logic led_beat;
  seg_t [SEG_DIGITS-1:0] hex;

  int cycles = 0;
  // Output samples and their cycle stamps, oldest first
  logic [15:0] got[$];
  int stamps[$];
  // Reference player position
  flash_addr_t model_addr = '0;
  logic model_bwd = 1'b0;
  logic model_used = 1'b0;
  // Reference loudness meter
  int meter_acc = 0;
  int meter_cnt = 0;
  logic [LED_COUNT-1:0] exp_bar = '0;
  logic exp_beat = 1'b0;

  ipod_top dut (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .kbd_ascii    (kbd_ascii),
    .kbd_valid    (kbd_valid),
    .keys         (keys),
    .flash_rsp    (flash_rsp),
    .flash_req    (flash_req),
    .sample       (sample),
    .sample_valid (sample_valid),
    .led_bar      (led_bar),
    .led_beat     (led_beat),
    .hex          (hex)
  );

  flash_model flash (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .req     (flash_req),
    .rsp     (flash_rsp)
  );

  // 50 MHz
  always #10 CLK_50M = ~CLK_50M;

  always @(posedge CLK_50M)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the tests did not finish", cycles);
      $display("Test failed");
      $fatal(1, "simulation timeout");
    end
  end

  function automatic int byte_mag(input logic [15:0] s);
    int b;
    b = int'(signed'(s[15:8]));
    return (b < 0) ? -b : b;
  endfunction

  // LED k on at average 16(k+1) or more
  function automatic logic [LED_COUNT-1:0] bar_pattern(input int avg);
    logic [LED_COUNT-1:0] bar;
    for (int k = 0; k < LED_COUNT; k++)
      bar[k] = (avg >= 16 * (k + 1));
    return bar;
  endfunction

  function automatic logic [7*SEG_DIGITS-1:0] expected_hex(input int p);
    logic [7*SEG_DIGITS-1:0] segs;
    logic [4*SEG_DIGITS-1:0] digits;
    digits = (4*SEG_DIGITS)'(p);
    for (int i = 0; i < SEG_DIGITS; i++)
      segs[7*i +: 7] = SEG_TABLE[digits[4*i +: 4]];
    return segs;
  endfunction

  // ====================
  // Output monitor
  // ====================
  always @(negedge CLK_50M)
  begin
    if (arst_n && sample_valid)
    begin
      got.push_back(sample);
      stamps.push_back(cycles);
    end
  end

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("[ERROR] %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Next value of the stream, then step the reference position
  task automatic model_next(output logic [15:0] v);
    logic [FLASH_AW:0] twice;
    twice = {model_addr, 1'b0};
    // First half is the low one going forward
    v = {twice[15:1], model_bwd ^ model_used};
    if (model_used)
      model_addr = model_bwd ? model_addr - 1'b1 : model_addr + 1'b1;
    model_used = ~model_used;
  endtask

  // Loudness of the expected stream, one block of 16 at a time
  task automatic meter_add(input logic [15:0] v);
    meter_acc = meter_acc + byte_mag(v);
    meter_cnt = meter_cnt + 1;
    // Block of 16 done
    if (meter_cnt == AVG_SAMPLES)
    begin
      exp_bar   = bar_pattern(meter_acc / AVG_SAMPLES);
      exp_beat  = ~exp_beat;
      meter_acc = 0;
      meter_cnt = 0;
    end
  endtask

  task automatic send_cmd(input logic [7:0] letter);
    @(posedge CLK_50M);
    #1;
    kbd_ascii = letter;
    kbd_valid = 1'b1;
    @(posedge CLK_50M);
    #1;
    kbd_valid = 1'b0;
    kbd_ascii = 8'h00;
    // Direction change or restart empties the word buffer
    if ((letter == "F" && model_bwd) || (letter == "B" && !model_bwd) || letter == "R")
      model_used = 1'b0;
    if (letter == "F")
      model_bwd = 1'b0;
    else if (letter == "B")
      model_bwd = 1'b1;
    if (letter == "R")
      model_addr = model_bwd ? LAST_WORD : '0;
  endtask

  task automatic next_sample(output int stamp);
    logic [15:0] exp_v;
    logic [15:0] got_v;
    while (got.size() == 0)
      @(posedge CLK_50M);
    got_v = got.pop_front();
    stamp = stamps.pop_front();
    model_next(exp_v);
    check_equal(64'(got_v), 64'(exp_v), "sample value");
    meter_add(exp_v);
  endtask

  task automatic check_stream(input int n);
    int stamp;
    repeat (n) next_sample(stamp);
  endtask

  task automatic press_key(input speed_keys_t pressed, input int old_p, input int new_p);
    @(posedge CLK_50M);
    #1 keys = pressed;
    // Two sync flops, then the period register
    repeat (2) @(posedge CLK_50M);
    @(negedge CLK_50M);
    check_equal(64'(hex), 64'(expected_hex(old_p)), "hex moved before the key was synced");
    @(negedge CLK_50M);
    check_equal(64'(hex), 64'(expected_hex(new_p)), "hex after key press");
    repeat (KEY_HOLD) @(posedge CLK_50M);
    #1 keys = KEYS_IDLE;
    repeat (6) @(posedge CLK_50M);
    @(negedge CLK_50M);
    check_equal(64'(hex), 64'(expected_hex(new_p)), "hex after key release");
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic test_reset_values();
    @(negedge CLK_50M);
    // 2272 is 08E0
    check_equal(64'(hex), 64'(expected_hex(BASE_PERIOD)), "hex after reset");
    check_equal(64'(sample), 64'(0), "sample after reset");
    check_equal(64'(led_beat), 64'(0), "led_beat after reset");
    repeat (3 * BASE_PERIOD)
    begin
      @(negedge CLK_50M);
      check_equal(64'(sample_valid), 64'(0), "sample_valid while paused");
      check_equal(64'(flash_req.read), 64'(0), "flash read while paused");
      check_equal(64'(led_bar), 64'(0), "led_bar after reset");
    end
  endtask

  task automatic test_play_forward();
    send_cmd("E");
    check_stream(40);
    send_cmd("D");
    repeat (5 * BASE_PERIOD) @(posedge CLK_50M);
    check_equal(64'(got.size()), 64'(0), "samples while paused");
    send_cmd("E");
    check_stream(4);
  endtask

  task automatic test_backward_restart();
    check_stream(1);
    send_cmd("B");
    check_stream(6);
    send_cmd("R");
    // Counts down from the top word's high half
    check_stream(6);
    send_cmd("F");
    send_cmd("R");
    check_stream(3);
  endtask

  task automatic test_speed_keys();
    int t0;
    int t1;
    int span;
    logic in_range;
    check_stream(1);
    send_cmd("D");
    press_key(KEY_UP, BASE_PERIOD, BASE_PERIOD - SPEED_STEP);
    press_key(KEY_UP, BASE_PERIOD - SPEED_STEP, BASE_PERIOD - 2 * SPEED_STEP);
    send_cmd("E");
    // Let the tick counter pick up the new period
    check_stream(2);
    next_sample(t0);
    repeat (8) next_sample(t1);
    span = t1 - t0;
    in_range = (span >= 8 * (BASE_PERIOD - 2 * SPEED_STEP) - SPACING_SLACK) &&
               (span <= 8 * (BASE_PERIOD - 2 * SPEED_STEP) + SPACING_SLACK);
    check_equal(64'(in_range), 64'(1), "sample spacing at the shorter period");
    check_stream(1);
    send_cmd("D");
    press_key(KEY_DOWN, BASE_PERIOD - 2 * SPEED_STEP, BASE_PERIOD - SPEED_STEP);
    press_key(KEY_RST, BASE_PERIOD - SPEED_STEP, BASE_PERIOD);
    send_cmd("E");
  endtask

  task automatic test_level_meter();
    check_stream(AVG_SAMPLES);
    repeat (2) @(negedge CLK_50M);
    check_equal(64'(led_bar), 64'(exp_bar), "led_bar");
    check_equal(64'(led_beat), 64'(exp_beat), "led_beat");
  endtask

  task automatic test_ignored_letters();
    check_stream(1);
    send_cmd("A");
    send_cmd("e");
    send_cmd("Q");
    send_cmd(8'h0D);
    check_equal(64'(hex), 64'(expected_hex(BASE_PERIOD)), "hex after unknown letters");
    check_stream(6);
  endtask

  initial
  begin
    arst_n    = 1'b0;
    kbd_ascii = 8'h00;
    kbd_valid = 1'b0;
    keys      = KEYS_IDLE;
    repeat (3) @(posedge CLK_50M);
    #1 arst_n = 1'b1;
    test_reset_values();
    test_play_forward();
    test_backward_restart();
    test_speed_keys();
    test_level_meter();
    test_ignored_letters();
    $display("Test passed");
    $finish;
  end

endmodule

/* flist.f */
rtl/ipod_pkg.sv
rtl/sample_rate_ctrl.sv
rtl/player_ctrl.sv
rtl/level_meter.sv
rtl/hex_display.sv
rtl/ipod_top.sv
dv/flash_model.sv
dv/tb_ipod.sv

/* Makefile */
# Verilator flow for the sample player
VERILATOR  ?= verilator
TOP        := tb_ipod
RTL_TOP    := ipod_top
FLIST      := flist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := Test passed
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(RTL_TOP)

# Pass only when the log holds the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
